//--- tb.f
+incdir+.
smc_pkg.sv
smc_sequencer.sv
smc_access_store.sv
smc_strobe_gen.sv
smc_strobe_top.sv
tb_smc_assertions.sv
tb_smc_strobe.sv

//--- Bender.yml
package:
  name: smc_strobe

sources:
  # Design
  - include_dirs:
      - .
    files:
      - smc_pkg.sv
      - smc_sequencer.sv
      - smc_access_store.sv
      - smc_strobe_gen.sv
      - smc_strobe_top.sv

  # Verification
  - target: test
    include_dirs:
      - .
    files:
      - tb_smc_assertions.sv
      - tb_smc_strobe.sv

//--- tb_smc_strobe.sv
// Directed testbench for the SMC strobe section with checker and cycle timeout
`timescale 1ns/100ps
`include "smc_settings.svh"

module tb_smc_strobe;

   import smc_pkg::*;

   localparam int CLK_HALF     = 20;   // 40 ns period
   localparam int DRIVE_DELAY  = 2;    // Input skew after rising edge
   localparam int RESET_CYCLES = 8;
   localparam int NUM_RANDOM   = 20;

   logic     sys_clk11;
   logic     n_sys_reset11;
   logic     valid_access;
   logic     n_read;
   logic     cs;
   byte_en_t n_be;
   ws_t      ws;
   logic     smc_n_rd;
   logic     smc_n_ext_oe;
   byte_en_t n_r_we;
   logic     n_r_wr;
   logic     smc_busy;
   logic     r_cs;

   int          cycle_count = 0;
   int          cycle_limit = 1000000;   // Replaced once the random accesses are known

   // Pregenerated so the run length is known up front
   ws_t      rand_ws     [NUM_RANDOM];
   logic     rand_n_read [NUM_RANDOM];
   logic     rand_cs     [NUM_RANDOM];
   byte_en_t rand_be     [NUM_RANDOM];

   smc_strobe_top DUT
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .valid_access  (valid_access),
      .n_read        (n_read),
      .cs            (cs),
      .n_be          (n_be),
      .ws            (ws),
      .smc_n_rd      (smc_n_rd),
      .smc_n_ext_oe  (smc_n_ext_oe),
      .n_r_we        (n_r_we),
      .n_r_wr        (n_r_wr),
      .smc_busy      (smc_busy),
      .r_cs          (r_cs)
   );

   //------------------------------------------------
   // Clock, timeout and assertion monitor
   //------------------------------------------------

   always #(CLK_HALF) sys_clk11 = ~sys_clk11;

   always @(posedge sys_clk11)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout after %0d cycles, an access never completed", cycle_limit);
         $display("Testbench failed");
         $fatal(1, "Run stopped by cycle limit");
      end
   end

   always @(negedge sys_clk11)
   begin
      if (DUT.u_assertions.fail_count != 0)
      begin
         $display("A protocol assertion on the DUT outputs failed");
         $display("Testbench failed");
         $fatal(1, "Run stopped by assertion failure");
      end
   end

   //------------------------------------------------
   // Checker and helpers
   //------------------------------------------------

   task automatic compare_values
   (
      input string       test,
      input string       what,
      input logic [31:0] expected,
      input logic [31:0] actual
   );
      if (actual !== expected)
      begin
         $display("Mismatch in %s: %s expected %0h, actual %0h",
                  test, what, expected, actual);
         $display("Testbench failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // All strobes inactive, nothing in flight
   task automatic check_idle_outputs(input string test);
      compare_values(test, "smc_n_rd", 1, smc_n_rd);
      compare_values(test, "smc_n_ext_oe", 1, smc_n_ext_oe);
      compare_values(test, "n_r_wr", 1, n_r_wr);
      compare_values(test, "n_r_we", {`SMC_NUM_BYTES{1'b1}}, n_r_we);
      compare_values(test, "smc_busy", 0, smc_busy);
      compare_values(test, "r_cs", 0, r_cs);
   endtask

   // Issues one access from an idle cycle and measures every output window;
   // returns in the first idle cycle after the access
   task automatic run_access
   (
      input string    test,
      input logic     acc_n_read,
      input logic     acc_cs,
      input byte_en_t acc_be,
      input ws_t      acc_ws,
      input bit       disturb      // Toggle inputs while busy
   );
      int   rd_low;
      int   wr_low;
      int   oe_low;
      int   busy_high;
      int   cs_high;
      int   rd_windows;
      int   wr_windows;
      int   idx;
      int   strobe_len;
      logic prev_rd;
      logic prev_wr;

      rd_low     = 0;
      wr_low     = 0;
      oe_low     = 0;
      busy_high  = 0;
      cs_high    = 0;
      rd_windows = 0;
      wr_windows = 0;
      idx        = 0;
      prev_rd    = 1'b1;
      prev_wr    = 1'b1;
      strobe_len = int'(acc_ws) + 1;   // RW phase length

      valid_access = 1'b1;
      n_read       = acc_n_read;
      cs           = acc_cs;
      n_be         = acc_be;
      ws           = acc_ws;

      do
      begin
         @(posedge sys_clk11);
         #(DRIVE_DELAY);
         if (idx == 0)
            compare_values(test, "busy after accept edge", 1, smc_busy);
         if (!smc_n_rd)
            rd_low++;
         if (!n_r_wr)
         begin
            wr_low++;
            compare_values(test, "n_r_we in write window", acc_be, n_r_we);
         end
         if (!smc_n_ext_oe)
            oe_low++;
         if (smc_busy)
            busy_high++;
         if (r_cs)
            cs_high++;
         if (!smc_n_rd && prev_rd)
            rd_windows++;      // Falling edge starts a window
         if (!n_r_wr && prev_wr)
            wr_windows++;
         prev_rd = smc_n_rd;
         prev_wr = n_r_wr;
         idx++;

         // Next cycle stimulus
         if (disturb && smc_busy)
         begin
            valid_access = 1'b1;
            n_read       = ~n_read;
            cs           = ~cs;
            n_be         = ~n_be;
            ws           = ws + 1'b1;
         end
         else
            valid_access = 1'b0;
      end
      while (smc_busy);

      compare_values(test, "smc_n_rd low cycles", acc_n_read ? 0 : strobe_len, rd_low);
      compare_values(test, "n_r_wr low cycles", acc_n_read ? strobe_len : 0, wr_low);
      compare_values(test, "smc_n_ext_oe low cycles", acc_n_read ? strobe_len : 0, oe_low);
      compare_values(test, "smc_busy high cycles", strobe_len + 1, busy_high);
      compare_values(test, "r_cs high cycles", acc_cs ? strobe_len : 0, cs_high);
      compare_values(test, "read windows", acc_n_read ? 0 : 1, rd_windows);
      compare_values(test, "write windows", acc_n_read ? 1 : 0, wr_windows);
      check_idle_outputs(test);
   endtask

   //------------------------------------------------
   // Directed tests
   //------------------------------------------------

   task automatic reset_values;
      check_idle_outputs("reset_values");
      repeat (2)
      begin
         @(posedge sys_clk11);
         #(DRIVE_DELAY);
         check_idle_outputs("reset_values");   // Still quiet with no request
      end
   endtask

   task automatic single_read;
      run_access("single_read", 1'b0, 1'b1, 4'b0000, 0, 1'b0);
   endtask

   task automatic byte_write;
      run_access("byte_write", 1'b1, 1'b1, 4'b1010, 3, 1'b0);
   endtask

   task automatic busy_inputs_ignored;
      run_access("busy_inputs_ignored", 1'b1, 1'b1, 4'b0110, 5, 1'b1);
   endtask

   task automatic random_back_to_back;
      for (int i = 0; i < NUM_RANDOM; i++)
         run_access("random_back_to_back", rand_n_read[i], rand_cs[i],
                    rand_be[i], rand_ws[i], 1'b0);
   endtask

   //------------------------------------------------
   // Main sequence
   //------------------------------------------------

   initial
   begin
      sys_clk11     = 1'b0;
      n_sys_reset11 = 1'b0;
      valid_access  = 1'b0;
      n_read        = 1'b1;
      cs            = 1'b0;
      n_be          = '1;
      ws            = '0;

      void'($urandom(32'h3d840ad7));
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         rand_ws[i]     = ws_t'($urandom % 16);
         rand_n_read[i] = 1'($urandom % 2);
         rand_cs[i]     = 1'($urandom % 2);
         rand_be[i]     = byte_en_t'($urandom);
      end

      // W+4 per access plus reset and slack
      cycle_limit = RESET_CYCLES + `SMC_TIMEOUT_MARGIN + (0 + 4) + (3 + 4) + (5 + 4);
      for (int i = 0; i < NUM_RANDOM; i++)
         cycle_limit = cycle_limit + int'(rand_ws[i]) + 4;

      repeat (RESET_CYCLES) @(posedge sys_clk11);
      #(DRIVE_DELAY);
      n_sys_reset11 = 1'b1;

      reset_values();
      single_read();
      byte_write();
      busy_inputs_ignored();
      random_back_to_back();

      @(negedge sys_clk11);   // Let the last assertions settle
      if (DUT.u_assertions.fail_count == 0)
      begin
         $display("Testbench passed");
         $finish;
      end
      else
      begin
         $display("Testbench failed");
         $fatal(1, "Protocol assertions failed during the run");
      end
   end

endmodule

//--- tb_smc_assertions.sv
// Protocol checks on the SMC strobe outputs, bound into the strobe top level
`timescale 1ns/100ps

module tb_smc_assertions
(
   input logic sys_clk11,      // System clock
   input logic n_sys_reset11,  // Async reset, active low
   input logic smc_n_rd,       // Read strobe
   input logic n_r_wr,         // Write strobe
   input logic smc_n_ext_oe,   // Bus driver enable
   input logic smc_busy        // Busy
);

   int unsigned fail_count = 0;   // Failed assertion count, read by the testbench

   //------------------------------------------------
   // Strobe relations
   //------------------------------------------------

   // One direction per access
   rd_wr_exclusive: assert property (
      @(posedge sys_clk11) disable iff (!n_sys_reset11)
      !(!smc_n_rd && !n_r_wr))
   else
   begin
      fail_count = fail_count + 1;
      $error("Read and write strobes low together");
   end

   // Bus driven exactly while writing
   oe_follows_wr: assert property (
      @(posedge sys_clk11) disable iff (!n_sys_reset11)
      smc_n_ext_oe == n_r_wr)
   else
   begin
      fail_count = fail_count + 1;
      $error("External output enable differs from write strobe");
   end

   // No strobe outside an access
   strobe_implies_busy: assert property (
      @(posedge sys_clk11) disable iff (!n_sys_reset11)
      (!smc_n_rd || !n_r_wr || !smc_n_ext_oe) |-> smc_busy)
   else
   begin
      fail_count = fail_count + 1;
      $error("Strobe active while not busy");
   end

endmodule

bind smc_strobe_top tb_smc_assertions u_assertions
(
   .sys_clk11     (sys_clk11),
   .n_sys_reset11 (n_sys_reset11),
   .smc_n_rd      (smc_n_rd),
   .n_r_wr        (n_r_wr),
   .smc_n_ext_oe  (smc_n_ext_oe),
   .smc_busy      (smc_busy)
);

//--- smc_strobe_top.sv
// SMC strobe section top joining sequencer, access store and strobe generator
`timescale 1ns/100ps

module smc_strobe_top
(
   input  logic              sys_clk11,      // System clock
   input  logic              n_sys_reset11,  // Async reset, active low
   input  logic              valid_access,   // Access request level
   input  logic              n_read,         // Low for read
   input  logic              cs,             // Chip select
   input  smc_pkg::byte_en_t n_be,           // Byte enables, active low
   input  smc_pkg::ws_t      ws,             // Wait states
   output logic              smc_n_rd,       // Read strobe
   output logic              smc_n_ext_oe,   // Bus driver enable
   output smc_pkg::byte_en_t n_r_we,         // Write byte enables
   output logic              n_r_wr,         // Write strobe
   output logic              smc_busy,       // Busy
   output logic              r_cs            // Registered chip select
);

   import smc_pkg::*;

   logic       access_start;   // Accept pulse
   smc_state_e next_state;     // Sequencer next state
   logic       smc_done;       // Last RW cycle
   logic       eff_n_read;     // Effective direction
   byte_en_t   eff_n_be;       // Effective byte enables

   //------------------------------------------------
   // Producer, buffer and consumer
   //------------------------------------------------

   smc_sequencer u_sequencer
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .valid_access  (valid_access),
      .ws            (ws),
      .access_start  (access_start),
      .next_state    (next_state),
      .smc_done      (smc_done)
   );

   smc_access_store u_access_store
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .access_start  (access_start),
      .smc_done      (smc_done),
      .n_read        (n_read),
      .cs            (cs),
      .n_be          (n_be),
      .eff_n_read    (eff_n_read),
      .eff_n_be      (eff_n_be),
      .r_cs          (r_cs)
   );

   smc_strobe_gen u_strobe_gen
   (
      .sys_clk11     (sys_clk11),
      .n_sys_reset11 (n_sys_reset11),
      .next_state    (next_state),
      .eff_n_read    (eff_n_read),
      .eff_n_be      (eff_n_be),
      .smc_n_rd      (smc_n_rd),
      .smc_n_ext_oe  (smc_n_ext_oe),
      .n_r_wr        (n_r_wr),
      .smc_busy      (smc_busy),
      .n_r_we        (n_r_we)
   );

endmodule

//--- smc_strobe_gen.sv
// SMC strobe generator for registered read, write, byte enable, bus enable and busy
`timescale 1ns/100ps

module smc_strobe_gen
(
   input  logic                sys_clk11,      // System clock
   input  logic                n_sys_reset11,  // Async reset, active low
   input  smc_pkg::smc_state_e next_state,     // State after this edge
   input  logic                eff_n_read,     // Access direction, low for read
   input  smc_pkg::byte_en_t   eff_n_be,       // Access byte enables
   output logic                smc_n_rd,       // Read strobe, active low
   output logic                smc_n_ext_oe,   // External bus driver enable, low
   output logic                n_r_wr,         // Write strobe, active low
   output logic                smc_busy,       // Access in progress
   output smc_pkg::byte_en_t   n_r_we          // Per-byte write enables, low
);

   import smc_pkg::*;

   logic rw_phase;    // Strobes active after this edge
   logic wr_access;   // Write in progress

   //------------------------------------------------
   // Strobe qualifiers
   //------------------------------------------------

   assign rw_phase  = (next_state == SMC_RW);
   assign wr_access = rw_phase && eff_n_read;   // High n_read means write

   //------------------------------------------------
   // Read and write strobes
   //------------------------------------------------

   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
      begin
         smc_n_rd     <= 1'b1;
         n_r_wr       <= 1'b1;
         n_r_we       <= '1;
         smc_n_ext_oe <= 1'b1;
      end
      else
      begin
         // Read strobe follows direction only inside RW
         smc_n_rd <= rw_phase ? eff_n_read : 1'b1;

         // Write strobe gated with byte lanes
         n_r_wr <= !wr_access;
         n_r_we <= wr_access ? eff_n_be : '1;

         // ASIC drives the bus for the whole write window
         smc_n_ext_oe <= !wr_access;
      end
   end

   //------------------------------------------------
   // Busy
   //------------------------------------------------

   // Covers RW and the FLOAT turnaround
   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
         smc_busy <= 1'b0;
      else
         smc_busy <= (next_state != SMC_IDLE);
   end

endmodule

//--- smc_access_store.sv
// SMC access store that holds direction, byte enables and chip select per access
`timescale 1ns/100ps

module smc_access_store
(
   input  logic              sys_clk11,      // System clock
   input  logic              n_sys_reset11,  // Async reset, active low
   input  logic              access_start,   // Load attributes
   input  logic              smc_done,       // Release attributes
   input  logic              n_read,         // Live direction, low for read
   input  logic              cs,             // Live chip select
   input  smc_pkg::byte_en_t n_be,           // Live byte enables, active low
   output logic              eff_n_read,     // Direction seen by strobes
   output smc_pkg::byte_en_t eff_n_be,       // Byte enables seen by strobes
   output logic              r_cs            // Registered chip select
);

   import smc_pkg::*;

   logic     r_n_read;   // Held direction
   byte_en_t r_n_be;     // Held byte enables

   //------------------------------------------------
   // Attribute registers
   //------------------------------------------------

   // Accept and done never coincide since they come from different states
   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
      begin
         r_n_read <= 1'b1;
         r_n_be   <= '1;
         r_cs     <= 1'b0;
      end
      else if (access_start)
      begin
         r_n_read <= n_read;
         r_n_be   <= n_be;
         r_cs     <= cs;       // Valid from the accept edge
      end
      else if (smc_done)
      begin
         // Back to inactive once the last RW cycle ends
         r_n_read <= 1'b1;
         r_n_be   <= '1;
         r_cs     <= 1'b0;
      end
   end

   //------------------------------------------------
   // Effective attributes
   //------------------------------------------------

   // Bypass on the accept cycle so strobes register the new access at edge A
   assign eff_n_read = access_start ? n_read : r_n_read;
   assign eff_n_be   = access_start ? n_be   : r_n_be;

endmodule

//--- smc_sequencer.sv
// SMC access sequencer that accepts requests, steps the state and counts wait states
`timescale 1ns/100ps

module smc_sequencer
(
   input  logic                sys_clk11,      // System clock
   input  logic                n_sys_reset11,  // Async reset, active low
   input  logic                valid_access,   // Access request level
   input  smc_pkg::ws_t        ws,             // Wait states for this access
   output logic                access_start,   // Request taken this cycle
   output smc_pkg::smc_state_e next_state,     // State after this edge
   output logic                smc_done        // Last RW cycle
);

   import smc_pkg::*;

   smc_state_e state_q;   // Current state
   ws_t        ws_cnt;    // Remaining wait states

   //------------------------------------------------
   // Acceptance and completion
   //------------------------------------------------

   // Requests only count while idle, anything during an access is dropped
   assign access_start = valid_access && (state_q == SMC_IDLE);

   // Counter exhausted in RW means this is the final strobe cycle
   assign smc_done = (state_q == SMC_RW) && (ws_cnt == '0);

   //------------------------------------------------
   // Next state
   //------------------------------------------------

   always_comb
   begin
      next_state = state_q;
      unique case (state_q)
         SMC_IDLE:
         begin
            if (access_start)
               next_state = SMC_RW;   // Strobes start at accept edge
         end
         SMC_RW:
         begin
            if (smc_done)
               next_state = SMC_FLOAT;
         end
         SMC_FLOAT:
            next_state = SMC_IDLE;    // One turnaround cycle only
         default:
            next_state = SMC_IDLE;
      endcase
   end

   //------------------------------------------------
   // State register and wait-state counter
   //------------------------------------------------

   always_ff @(posedge sys_clk11 or negedge n_sys_reset11)
   begin
      if (!n_sys_reset11)
      begin
         state_q <= SMC_IDLE;
         ws_cnt  <= '0;
      end
      else
      begin
         state_q <= next_state;

         // Load on accept, count down through RW
         if (access_start)
            ws_cnt <= ws;
         else if ((state_q == SMC_RW) && (ws_cnt != '0))
            ws_cnt <= ws_cnt - 1'b1;   // Holds at zero on the done cycle
      end
   end

endmodule

//--- smc_pkg.sv
// SMC strobe section types for controller state, byte enables and wait states
`include "smc_settings.svh"

package smc_pkg;

   //------------------------------------------------
   // Controller state
   //------------------------------------------------

   // Single access only, so no LE or STORE phase
   typedef enum logic [1:0]
   {
      SMC_IDLE  = 2'd0,   // Waiting for an access
      SMC_RW    = 2'd1,   // Strobes active, stretched by wait states
      SMC_FLOAT = 2'd2    // Turnaround before next access
   } smc_state_e;

   //------------------------------------------------
   // Payload types
   //------------------------------------------------

   // Active-low byte lane enables
   typedef logic [`SMC_NUM_BYTES-1:0] byte_en_t;

   // Wait-state count for the RW phase
   typedef logic [`SMC_WS_WIDTH-1:0] ws_t;

endpackage

//--- smc_settings.svh
// SMC strobe section settings for counter width, byte lanes and sim limits
`ifndef SMC_SETTINGS_SVH
`define SMC_SETTINGS_SVH

//------------------------------------------------
// Datapath sizing
//------------------------------------------------

// Width of the wait-state count and its counter
`define SMC_WS_WIDTH 8

// Byte lanes on the external bus, one active-low enable each
`define SMC_NUM_BYTES 4

//------------------------------------------------
// Simulation
//------------------------------------------------

// Slack cycles added on top of the computed run length
`define SMC_TIMEOUT_MARGIN 64

`endif
